/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_flash_bridge
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/flash_bridge_pkg.sv */
package flash_bridge_pkg;

	////////////////////////////////////////////////////////////
	// Packet format
	////////////////////////////////////////////////////////////
	localparam int PKT_W        = 65;  // One FIFO word
	localparam int FLASH_ADDR_W = 24;
	localparam int DEST_W       = 3;
	localparam int SRC_W        = 2;
	localparam int INDEX_W      = 3;
	localparam int DATA_W       = PKT_W - DEST_W - SRC_W - INDEX_W - 1 - FLASH_ADDR_W;

	// SPI frame sizes
	localparam int TX_W    = 64;  // Longest frame, opcode + addr + 4 bytes
	localparam int NBITS_W = 7;
	localparam int RX_W    = 32;

	// Device codes
	localparam logic [DEST_W-1:0] DEST_SPI  = 3'b001;
	localparam logic [DEST_W-1:0] RESP_DEST = 3'b000;  // MMU
	localparam logic [SRC_W-1:0]  RESP_SRC  = 2'b01;   // SPI

	typedef enum logic [INDEX_W-1:0] {
		IDX_RD4  = 3'd0,
		IDX_RD1  = 3'd1,
		IDX_RD2  = 3'd2,
		IDX_END  = 3'd3,  // Bootloader end marker, discarded
		IDX_WR4  = 3'd4,
		IDX_WR1  = 3'd5,
		IDX_WR2  = 3'd6,
		IDX_BOOT = 3'd7   // Bootloader start, discarded
	} pkt_index_e;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} flash_op_e;

	// Serial NOR opcodes
	typedef enum logic [7:0] {
		CMD_PROG = 8'h02,
		CMD_READ = 8'h03,
		CMD_WRDI = 8'h04,
		CMD_RDSR = 8'h05,
		CMD_WREN = 8'h06
	} flash_cmd_e;

	typedef struct packed {
		logic [DEST_W-1:0]       dest;
		logic [SRC_W-1:0]        src;
		logic [INDEX_W-1:0]      index;
		logic                    rd_flag;
		logic [FLASH_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]       data;
	} fifo_pkt_t;

	typedef struct packed {
		flash_op_e               op;
		pkt_index_e              index;
		logic [2:0]              nbytes;  // 1 to 4
		logic [FLASH_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]       wdata;
	} flash_cmd_t;

	typedef struct packed {
		logic [TX_W-1:0]    tx;     // Sent MSB first
		logic [NBITS_W-1:0] nbits;
	} spi_frame_t;

endpackage

/* design/flash_bridge_top.sv */
`timescale 1ns/1ps

module flash_bridge_top import flash_bridge_pkg::*; #(
	parameter int CLK_DIV = 2  // SCLK half period in CLK cycles
) (
	input  logic      CLK,
	input  logic      reset,
	input  logic      pndgn,
	input  fifo_pkt_t D_pop,
	input  logic      MISO,
	output logic      pop,
	output logic      push,
	output fifo_pkt_t D_push,
	output logic      MOSI,
	output logic      SCLK,
	output logic      SCS
);

	flash_cmd_t      cmd;
	logic            cmd_valid;
	logic            cmd_ready;
	spi_frame_t      frame;
	logic            start;
	logic            done;
	logic [RX_W-1:0] rx_word;
	logic            rd_done;

	////////////////////////////////////////////////////////////
	// Packet in, flash commands out
	////////////////////////////////////////////////////////////
	flash_pkt_decode decode_i (
		.CLK(CLK), .reset(reset), .pndgn(pndgn), .D_pop(D_pop), .cmd_ready(cmd_ready),
		.pop(pop), .cmd(cmd), .cmd_valid(cmd_valid)
	);

	flash_sequencer seq_i (
		.CLK(CLK), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid), .done(done),
		.rx_word(rx_word), .cmd_ready(cmd_ready), .frame(frame), .start(start),
		.rd_done(rd_done)
	);

	spi_shifter #(.CLK_DIV(CLK_DIV)) spi_i (
		.CLK(CLK), .reset(reset), .frame(frame), .start(start), .MISO(MISO),
		.done(done), .rx_word(rx_word), .MOSI(MOSI), .SCLK(SCLK), .SCS(SCS)
	);

	// Read response
	flash_resp_build resp_i (
		.CLK(CLK), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.rd_done(rd_done), .rx_word(rx_word), .push(push), .D_push(D_push)
	);

endmodule

/* design/flash_pkt_decode.sv */
`timescale 1ns/1ps

module flash_pkt_decode import flash_bridge_pkg::*; (
	input  logic       CLK,
	input  logic       reset,
	input  logic       pndgn,
	input  fifo_pkt_t  D_pop,
	input  logic       cmd_ready,
	output logic       pop,
	output flash_cmd_t cmd,
	output logic       cmd_valid
);

	flash_cmd_t cmd_next;
	logic       keep;

	// Index to operation and byte count
	always_comb begin
		cmd_next.op     = OP_READ;
		cmd_next.index  = pkt_index_e'(D_pop.index);
		cmd_next.nbytes = 3'd4;
		cmd_next.addr   = D_pop.addr;
		cmd_next.wdata  = D_pop.data;
		keep            = (D_pop.dest == DEST_SPI);
		case (cmd_next.index)
			IDX_RD4: cmd_next.nbytes = 3'd4;
			IDX_RD1: cmd_next.nbytes = 3'd1;
			IDX_RD2: cmd_next.nbytes = 3'd2;
			IDX_WR4: cmd_next.op = OP_WRITE;
			IDX_WR1: begin
				cmd_next.op     = OP_WRITE;
				cmd_next.nbytes = 3'd1;
			end
			IDX_WR2: begin
				cmd_next.op     = OP_WRITE;
				cmd_next.nbytes = 3'd2;
			end
			default: keep = 1'b0;  // END and BOOT are dropped
		endcase
	end

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			pop       <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			pop <= pndgn && !pop && !cmd_valid;  // Only when holding nothing
			if (pop)
				cmd_valid <= keep;
			else if (cmd_ready)
				cmd_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (pop)
			cmd <= cmd_next;  // D_pop sampled in the pop cycle
	end

	a_pop_single: assert property (@(posedge CLK) disable iff (reset) pop |=> !pop);

	// FIFO must still hold the word being popped
	a_pop_pending: assert property (@(posedge CLK) disable iff (reset) pop |-> pndgn);

endmodule

/* design/flash_resp_build.sv */
`timescale 1ns/1ps

module flash_resp_build import flash_bridge_pkg::*; (
	input  logic            CLK,
	input  logic            reset,
	input  flash_cmd_t      cmd,
	input  logic            cmd_valid,
	input  logic            cmd_ready,
	input  logic            rd_done,
	input  logic [RX_W-1:0] rx_word,
	output logic            push,
	output fifo_pkt_t       D_push
);

	pkt_index_e              idx_q;
	logic [FLASH_ADDR_W-1:0] addr_q;
	logic [2:0]              nbytes_q;
	logic [DATA_W-1:0]       rd_data;

	// First byte read lands in data[7:0]
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			if (i < nbytes_q)
				rd_data[8*i +: 8] = rx_word[RX_W-1-8*i -: 8];
			else
				rd_data[8*i +: 8] = 8'h00;  // Unused bytes
		end
	end

	always_ff @(posedge CLK) begin
		if (cmd_valid && cmd_ready) begin
			idx_q    <= cmd.index;
			addr_q   <= cmd.addr;
			nbytes_q <= cmd.nbytes;
		end
		if (rd_done) begin
			D_push.dest    <= RESP_DEST;
			D_push.src     <= RESP_SRC;
			D_push.index   <= idx_q;
			D_push.rd_flag <= 1'b1;
			D_push.addr    <= addr_q;
			D_push.data    <= rd_data;
		end
	end

	always_ff @(posedge CLK or posedge reset) begin
		if (reset)
			push <= 1'b0;
		else
			push <= rd_done;
	end

endmodule

/* design/flash_sequencer.sv */
`timescale 1ns/1ps

module flash_sequencer import flash_bridge_pkg::*; (
	input  logic            CLK,
	input  logic            reset,
	input  flash_cmd_t      cmd,
	input  logic            cmd_valid,
	input  logic            done,
	input  logic [RX_W-1:0] rx_word,
	output logic            cmd_ready,
	output spi_frame_t      frame,
	output logic            start,
	output logic            rd_done
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_WREN,
		S_WREN_WAIT,
		S_PROG,
		S_PROG_WAIT,
		S_WRDI,
		S_WRDI_WAIT,
		S_RDSR,
		S_RDSR_WAIT,
		S_READ,
		S_READ_WAIT
	} seq_state_e;

	seq_state_e state;
	flash_cmd_t cmd_q;

	assign cmd_ready = (state == S_IDLE);

	////////////////////////////////////////////////////////////
	// Command sequencing
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state   <= S_IDLE;
			start   <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			start   <= 1'b0;
			rd_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cmd_valid)
						state <= (cmd.op == OP_WRITE) ? S_WREN : S_READ;
				end
				S_WREN: begin
					start <= 1'b1;
					state <= S_WREN_WAIT;
				end
				S_WREN_WAIT: if (done) state <= S_PROG;
				S_PROG: begin
					start <= 1'b1;
					state <= S_PROG_WAIT;
				end
				S_PROG_WAIT: if (done) state <= S_WRDI;
				S_WRDI: begin
					start <= 1'b1;
					state <= S_WRDI_WAIT;
				end
				S_WRDI_WAIT: if (done) state <= S_RDSR;
				S_RDSR: begin
					start <= 1'b1;
					state <= S_RDSR_WAIT;
				end
				S_RDSR_WAIT: begin
					if (done)
						state <= rx_word[0] ? S_RDSR : S_IDLE;  // Poll while busy
				end
				S_READ: begin
					start <= 1'b1;
					state <= S_READ_WAIT;
				end
				S_READ_WAIT: begin
					if (done) begin
						rd_done <= 1'b1;
						state   <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Frame contents
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (cmd_valid && cmd_ready)
			cmd_q <= cmd;
		case (state)
			S_WREN: begin
				frame.tx    <= {CMD_WREN, 56'h0};
				frame.nbits <= 7'd8;
			end
			S_PROG: begin
				// Data byte 0 goes out first
				frame.tx    <= {CMD_PROG, cmd_q.addr, cmd_q.wdata[7:0], cmd_q.wdata[15:8],
					cmd_q.wdata[23:16], cmd_q.wdata[31:24]};
				frame.nbits <= 7'd32 + {1'b0, cmd_q.nbytes, 3'b000};
			end
			S_WRDI: begin
				frame.tx    <= {CMD_WRDI, 56'h0};
				frame.nbits <= 7'd8;
			end
			S_RDSR: begin
				frame.tx    <= {CMD_RDSR, 56'hFF_FFFF_FFFF_FFFF};
				frame.nbits <= 7'd16;  // Opcode plus status byte
			end
			S_READ: begin
				frame.tx    <= {CMD_READ, cmd_q.addr, 32'hFFFF_FFFF};
				frame.nbits <= 7'd64;
			end
			default: frame <= frame;
		endcase
	end

	// Decode must hold its command until it is taken
	a_cmd_hold: assert property (@(posedge CLK) disable iff (reset)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

/* design/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter import flash_bridge_pkg::*; #(
	parameter int CLK_DIV = 2
) (
	input  logic            CLK,
	input  logic            reset,
	input  spi_frame_t      frame,
	input  logic            start,
	input  logic            MISO,
	output logic            done,
	output logic [RX_W-1:0] rx_word,
	output logic            MOSI,
	output logic            SCLK,
	output logic            SCS
);

	localparam int DIV_W = $clog2(CLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

	typedef enum logic [1:0] {SH_IDLE, SH_SETUP, SH_LOW, SH_HIGH} sh_state_e;

	sh_state_e          state;
	logic [DIV_W-1:0]   div_cnt;
	logic [NBITS_W-1:0] bits_left;
	logic [TX_W-1:0]    tx_sh;
	logic [RX_W-1:0]    rx_sh;
	logic               half_end;

	assign half_end = (div_cnt == DIV_LAST);
	assign rx_word  = rx_sh;

	////////////////////////////////////////////////////////////
	// Mode 0 clock and chip select
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state     <= SH_IDLE;
			div_cnt   <= '0;
			bits_left <= '0;
			SCS       <= 1'b1;
			SCLK      <= 1'b0;
			MOSI      <= 1'b0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				SH_IDLE: begin
					if (start) begin
						state     <= SH_SETUP;
						SCS       <= 1'b0;
						MOSI      <= frame.tx[TX_W-1];  // First bit ahead of SCLK
						bits_left <= frame.nbits;
						div_cnt   <= '0;
					end
				end
				SH_SETUP: state <= SH_LOW;
				SH_LOW: begin
					div_cnt <= half_end ? '0 : div_cnt + 1'b1;
					if (half_end) begin
						SCLK      <= 1'b1;  // Rising edge
						bits_left <= bits_left - 1'b1;
						state     <= SH_HIGH;
					end
				end
				SH_HIGH: begin
					div_cnt <= half_end ? '0 : div_cnt + 1'b1;
					if (half_end) begin
						SCLK <= 1'b0;
						if (bits_left == '0) begin
							SCS   <= 1'b1;
							MOSI  <= 1'b0;
							done  <= 1'b1;
							state <= SH_IDLE;
						end else begin
							MOSI  <= tx_sh[TX_W-2];
							state <= SH_LOW;
						end
					end
				end
				default: state <= SH_IDLE;
			endcase
		end
	end

	// Shift registers
	always_ff @(posedge CLK) begin
		if (state == SH_IDLE && start)
			tx_sh <= frame.tx;
		else if (state == SH_HIGH && half_end)
			tx_sh <= tx_sh << 1;
		if (state == SH_LOW && half_end)
			rx_sh <= {rx_sh[RX_W-2:0], MISO};  // Sample as SCLK rises
	end

	a_start_idle: assert property (@(posedge CLK) disable iff (reset) start |-> SCS);

endmodule

/* sim.f */
design/flash_bridge_pkg.sv
design/flash_pkt_decode.sv
design/flash_sequencer.sv
design/spi_shifter.sv
design/flash_resp_build.sv
design/flash_bridge_top.sv
tests/spi_flash_model.sv
tests/tb_flash_bridge.sv

/* tests/spi_flash_model.sv */
`timescale 1ns/1ps

module spi_flash_model import flash_bridge_pkg::*; (
	input  logic SCLK,
	input  logic SCS,
	input  logic MOSI,
	output logic MISO,
	output logic busy_err
);

	logic [7:0]  mem [0:255];
	logic [63:0] rx_bits;  // Bits shifted in during this frame
	logic [7:0]  opcode;
	logic [7:0]  base;     // Low address byte, array wraps at 256
	logic [7:0]  status;
	logic        wel;      // Write-enable latch
	int          nbit;
	int          busy_polls;

	assign status = {6'b0, wel, busy_polls != 0};

	initial begin
		for (int a = 0; a < 256; a++)
			mem[a] = 8'hFF;
		rx_bits    = '0;
		opcode     = '0;
		base       = '0;
		wel        = 1'b0;
		nbit       = 0;
		busy_polls = 0;
		MISO       = 1'b0;
		busy_err   = 1'b0;
	end

	always @(negedge SCS) nbit = 0;  // New frame

	// Mode 0 command bits on the rising edge
	always @(posedge SCLK) begin
		if (!SCS) begin
			rx_bits = {rx_bits[62:0], MOSI};
			nbit    = nbit + 1;
			if (nbit == 8) begin
				opcode = rx_bits[7:0];
				if ((opcode == CMD_READ || opcode == CMD_PROG) && busy_polls != 0)
					busy_err = 1'b1;  // Access during program
			end
			if (nbit == 32)
				base = rx_bits[7:0];
		end
	end

	// Reply bits change on the falling edge
	always @(negedge SCLK) begin
		if (!SCS) begin
			if (opcode == CMD_READ && nbit >= 32)
				MISO <= mem[8'(base + (nbit - 32) / 8)][7 - (nbit - 32) % 8];
			else if (opcode == CMD_RDSR && nbit >= 8)
				MISO <= status[7 - (nbit - 8) % 8];
			else
				MISO <= 1'b0;
		end
	end

	always @(posedge SCS) begin
		int nb;
		nb = (nbit - 32) / 8;  // Data bytes in a PROG frame
		case (opcode)
			CMD_WREN: wel = 1'b1;
			CMD_WRDI: wel = 1'b0;
			CMD_RDSR: begin
				if (busy_polls != 0)
					busy_polls = busy_polls - 1;
			end
			CMD_PROG: begin
				if (wel) begin
					for (int i = 0; i < nb; i++)
						mem[8'(base + i)] = rx_bits[8 * (nb - 1 - i) +: 8];
					busy_polls = 3;  // Busy for the next three polls
				end
			end
			default: ;
		endcase
	end

endmodule

/* tests/tb_flash_bridge.sv */
`timescale 1ns/1ps

module tb_flash_bridge import flash_bridge_pkg::*; ();

	localparam int CLK_DIV        = 2;
	localparam int TIMEOUT_CYCLES = 40000;  // About 60 packets at 600 cycles
	localparam int WRITE_FRAMES   = 7;      // WREN, PROG, WRDI, four RDSR

	logic       CLK   = 1'b0;
	logic       reset = 1'b1;
	logic       pndgn = 1'b0;
	fifo_pkt_t  D_pop = '0;
	logic       MISO;
	logic       pop;
	logic       push;
	fifo_pkt_t  D_push;
	logic       MOSI;
	logic       SCLK;
	logic       SCS;
	logic       busy_err;
	fifo_pkt_t  in_q[$];
	fifo_pkt_t  exp_q[$];
	logic [7:0] shadow [0:255];
	int         seed       = 32'h6bee535b;
	int         exp_frames = 0;
	int         frame_cnt  = 0;
	int         cycle_cnt  = 0;
	logic       pop_q      = 1'b0;
	logic       scs_q      = 1'b1;

	always #2 CLK = ~CLK;

	flash_bridge_top #(.CLK_DIV(CLK_DIV)) dut_i (
		.CLK(CLK), .reset(reset), .pndgn(pndgn), .D_pop(D_pop), .MISO(MISO),
		.pop(pop), .push(push), .D_push(D_push), .MOSI(MOSI), .SCLK(SCLK), .SCS(SCS)
	);

	spi_flash_model flash_i (
		.SCLK(SCLK), .SCS(SCS), .MOSI(MOSI), .MISO(MISO), .busy_err(busy_err)
	);

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic int nbytes_of(input logic [2:0] idx);
		case (idx)
			IDX_RD1, IDX_WR1: return 1;
			IDX_RD2, IDX_WR2: return 2;
			default:          return 4;
		endcase
	endfunction

	function automatic fifo_pkt_t expected_resp(input fifo_pkt_t req);
		fifo_pkt_t resp;
		resp         = '0;  // Bytes above nbytes stay zero
		resp.dest    = RESP_DEST;
		resp.src     = RESP_SRC;
		resp.index   = req.index;
		resp.rd_flag = 1'b1;
		resp.addr    = req.addr;
		for (int i = 0; i < nbytes_of(req.index); i++)
			resp.data[8*i +: 8] = shadow[8'(req.addr[7:0] + i)];
		return resp;
	endfunction

	function automatic void write_shadow(input fifo_pkt_t req);
		for (int i = 0; i < nbytes_of(req.index); i++)
			shadow[8'(req.addr[7:0] + i)] = req.data[8*i +: 8];
	endfunction

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic compare_pkt(input string name, input fifo_pkt_t got, input fifo_pkt_t exp);
		if (got !== exp)
			stop_fail($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_fail($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic queue_pkt(input logic [2:0] dest, input logic [2:0] idx,
		input logic [23:0] addr, input logic [31:0] data);
		fifo_pkt_t p;
		p.dest    = dest;
		p.src     = 2'($random(seed));
		p.index   = idx;
		p.rd_flag = 1'b0;
		p.addr    = addr;
		p.data    = data;
		if (dest == DEST_SPI && idx inside {IDX_RD4, IDX_RD1, IDX_RD2}) begin
			exp_q.push_back(expected_resp(p));
			exp_frames += 1;
		end else if (dest == DEST_SPI && idx inside {IDX_WR4, IDX_WR1, IDX_WR2}) begin
			write_shadow(p);
			exp_frames += WRITE_FRAMES;
		end
		in_q.push_back(p);
	endtask

	// Show-ahead transmit FIFO
	always @(posedge CLK) begin
		if (pop && in_q.size() != 0)
			in_q.delete(0);
		pndgn <= (in_q.size() != 0);
		D_pop <= (in_q.size() != 0) ? in_q[0] : '0;
	end

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		pop_q     <= pop;
		scs_q     <= SCS;
		if (!reset && scs_q && !SCS)
			frame_cnt <= frame_cnt + 1;  // One per SPI frame
		if (cycle_cnt == TIMEOUT_CYCLES)
			stop_fail($sformatf("Timeout, run not done after %0d cycles", TIMEOUT_CYCLES));
		else if (busy_err)
			stop_fail("Flash model got READ or PROG while a program was in progress");
		else if (!reset && pop && pop_q)
			stop_fail("pop stayed high for more than one cycle");
		else if (!reset && pop && !pndgn)
			stop_fail("pop was raised while the FIFO was empty");
	end

	// Response checker
	always @(posedge CLK) begin
		if (!reset && push) begin
			if (exp_q.size() == 0)
				stop_fail("push seen with no read response outstanding");
			else
				compare_pkt("D_push", D_push, exp_q.pop_front());
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	initial begin
		logic [23:0] a;
		logic [31:0] d;
		for (int i = 0; i < 256; i++)
			shadow[i] = 8'hFF;
		repeat (8) @(posedge CLK);
		reset <= 1'b0;
		repeat (20) begin
			@(posedge CLK);
			if (!SCS || pop || push)
				stop_fail("Bridge was active before any packet was queued");
		end

		@(negedge CLK);
		for (int n = 0; n < 10; n++) begin
			a = 24'($random(seed));
			d = $random(seed);
			queue_pkt(DEST_SPI, IDX_WR4, a, d);
			queue_pkt(DEST_SPI, IDX_RD4, a, $random(seed));  // Read right behind write
			case (n % 3)
				0:       queue_pkt(3'b010, IDX_RD4, a, d);  // Other device
				1:       queue_pkt(DEST_SPI, IDX_BOOT, a, d);
				default: queue_pkt(DEST_SPI, IDX_END, a, d);
			endcase
		end
		for (int n = 0; n < 6; n++) begin
			a = 24'($random(seed));
			queue_pkt(DEST_SPI, IDX_WR2, a, $random(seed));
			queue_pkt(DEST_SPI, IDX_WR1, a + 24'd2, $random(seed));
			queue_pkt(DEST_SPI, IDX_RD1, a + 24'd2, $random(seed));
			queue_pkt(DEST_SPI, IDX_RD2, a, $random(seed));
			queue_pkt(DEST_SPI, IDX_RD4, a, $random(seed));
		end

		while (exp_q.size() != 0 || in_q.size() != 0)
			@(negedge CLK);
		repeat (100) @(negedge CLK);  // Room for a stray push or frame
		for (int i = 0; i < 256; i++)
			compare_byte($sformatf("flash mem[%0d]", i), flash_i.mem[i], shadow[i]);
		if (frame_cnt == exp_frames) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stop_fail($sformatf("FAILED frame_cnt: got %h, expected %h", frame_cnt, exp_frames));
		end
	end

endmodule
